/* compile.f */
+incdir+logic
logic/fp_format_pkg.sv
logic/fpu_xfer_pkg.sv
logic/fpu_req_intake.sv
logic/fp_align_stage.sv
logic/fp_addsub_normalize.sv
logic/fpu_result_return.sv
logic/fpu_addsub_top.sv
dv/fpu_addsub_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the FPU add/subtract testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=fpu_addsub_sim
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module fpu_addsub_tb \
    -Mdir "${BUILD_DIR}" -o "${SIM_BIN}"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./${BUILD_DIR}/${SIM_BIN}" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"
if [ ${sim_status} -ne 0 ]; then
    echo "simulation exited with status ${sim_status}"
    exit 1
fi

if grep -qx "PASS: all tests" "${LOG_FILE}"; then
    exit 0
fi
echo "simulation did not report success, see ${LOG_FILE}"
exit 1

/* dv/fpu_addsub_tb.sv */
`timescale 1ns/1ps

module fpu_addsub_tb
    import fpu_xfer_pkg::*;
();

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        fpu_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] word;
        logic        ovf;
        logic        unf;
    } vector_t;

    logic           clk;
    logic           reset;
    logic           req;
    fpu_operation_t operation;
    logic           ack;
    logic           res_req;
    logic           res_ack;
    fpu_result_t    result;

    vector_t        vectors[$];
    int             errors;
    int             tests_passed;
    int             tests_failed;
    logic           aborted;
    logic [31:0]    lcg_state;

    fpu_addsub_top fpu_addsub_top_inst (
        .i_clk       (clk),
        .i_reset     (reset),
        .i_req       (req),
        .i_operation (operation),
        .o_ack       (ack),
        .o_res_req   (res_req),
        .i_res_ack   (res_ack),
        .o_result    (result)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_vector(input fpu_op_e op, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] word, input logic ovf, input logic unf);
        vector_t v;
        v.op   = op;
        v.a    = a;
        v.b    = b;
        v.word = word;
        v.ovf  = ovf;
        v.unf  = unf;
        vectors.push_back(v);
    endtask

    ////////////////////
    // stimulus table
    ////////////////////
    task automatic load_vectors();
        add_vector(FPU_ADD, 32'h3f80_0000, 32'h4000_0000, 32'h4040_0000, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'h3f00_0000, 32'h3e80_0000, 32'h3f40_0000, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'h40a0_0000, 32'hc000_0000, 32'h4040_0000, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'hbf80_0000, 32'h3f00_0000, 32'hbf00_0000, 1'b0, 1'b0);
        // carry out of the mantissa add
        add_vector(FPU_ADD, 32'h4040_0000, 32'h4040_0000, 32'h40c0_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'h4000_0000, 32'h40a0_0000, 32'hc040_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'hbf80_0000, 32'h4000_0000, 32'hc040_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'h40f0_0000, 32'h40f0_0000, 32'h0000_0000, 1'b0, 1'b0);
        // tie cases, odd lsb rounds up and even lsb stays
        add_vector(FPU_ADD, 32'h3f80_0000, 32'h3440_0000, 32'h3f80_0002, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'h3f80_0000, 32'h3380_0000, 32'h3f80_0000, 1'b0, 1'b0);
        // about 3.0e38 twice
        add_vector(FPU_ADD, 32'h7f61_b1e6, 32'h7f61_b1e6, 32'h7f80_0000, 1'b1, 1'b0);
        add_vector(FPU_ADD, 32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'h7f80_0000, 32'h7f80_0000, 32'h7fc0_0000, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'h7f80_0001, 32'h3f80_0000, 32'h7fc0_0000, 1'b0, 1'b0);
        add_vector(FPU_ADD, 32'h0000_0000, 32'h40a0_0000, 32'h40a0_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'h3fc0_0000, 32'h0000_0000, 32'h3fc0_0000, 1'b0, 1'b0);
        add_vector(FPU_SUB, 32'h0000_0000, 32'h4000_0000, 32'hc000_0000, 1'b0, 1'b0);
        // 1.5 x 2^-126 minus 2^-126
        add_vector(FPU_SUB, 32'h00c0_0000, 32'h0080_0000, 32'h0000_0000, 1'b0, 1'b1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, expected);
            errors++;
        end
    endtask

    ////////////////////
    // bounded waits
    ////////////////////
    task automatic wait_ack(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (ack !== level && cycles < WAIT_LIMIT);
        if (ack !== level) begin
            $display("ERROR at %0t ns: o_ack never went to %b within %0d cycles",
                     $time, level, WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic wait_res_req(input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (res_req !== level && cycles < WAIT_LIMIT);
        if (res_req !== level) begin
            $display("ERROR at %0t ns: o_res_req never went to %b within %0d cycles",
                     $time, level, WAIT_LIMIT);
            errors++;
            aborted = 1'b1;
        end
    endtask

    ////////////////////
    // producer and consumer
    ////////////////////
    task automatic send_operations();
        for (int i = 0; i < vectors.size() && !aborted; i++) begin
            @(posedge clk);
            req              <= 1'b1;
            operation.op     <= vectors[i].op;
            operation.a.raw  <= vectors[i].a;
            operation.b.raw  <= vectors[i].b;
            wait_ack(1'b1);
            @(posedge clk);
            req <= 1'b0;
            // next request only once ack is low again
            wait_ack(1'b0);
        end
    endtask

    task automatic collect_results();
        vector_t v;
        int      delay;
        int      errors_before;
        for (int i = 0; i < vectors.size() && !aborted; i++) begin
            v             = vectors[i];
            errors_before = errors;
            wait_res_req(1'b1);
            if (!aborted) begin
                check_value("o_result.word", result.word.raw, v.word);
                check_value("o_result.overflow", 32'(result.overflow), 32'(v.ovf));
                check_value("o_result.underflow", 32'(result.underflow), 32'(v.unf));
                // slow consumer, 0 to 5 cycles
                delay = int'((next_random() >> 16) % 6);
                repeat (delay + 1) @(posedge clk);
                res_ack <= 1'b1;
                wait_res_req(1'b0);
                @(posedge clk);
                res_ack <= 1'b0;
                if (errors == errors_before) begin
                    tests_passed++;
                end else begin
                    tests_failed++;
                end
                $display("test %2d: %s %h, %h -> %h ovf %b unf %b  %s", i, v.op.name(),
                         v.a, v.b, result.word.raw, result.overflow, result.underflow,
                         (errors == errors_before) ? "ok" : "mismatch");
            end
        end
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        req          = 1'b0;
        operation    = '0;
        res_ack      = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        aborted      = 1'b0;
        lcg_state    = 32'hb3d5f4b1;
        load_vectors();

        repeat (10) @(posedge clk);
        reset <= 1'b0;

        fork
            send_operations();
            collect_results();
        join

        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 tests_passed + tests_failed, tests_passed, tests_failed, errors);
        if (errors == 0 && tests_passed == vectors.size()) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* logic/fpu_addsub_top.sv */
`timescale 1ns/1ps

module fpu_addsub_top
    import fpu_xfer_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_req,
    input  fpu_operation_t i_operation,
    output logic           o_ack,
    output logic           o_res_req,
    input  logic           i_res_ack,
    output fpu_result_t    o_result
);

    logic           op_valid;
    fpu_operation_t op;
    logic           align_take;
    logic           align_valid;
    fpu_aligned_t   aligned;
    logic           norm_take;
    logic           norm_valid;
    fpu_result_t    norm_result;
    logic           ret_take;

    fpu_req_intake fpu_req_intake_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_req       (i_req),
        .i_operation (i_operation),
        .o_ack       (o_ack),
        .o_op_valid  (op_valid),
        .o_op        (op),
        .i_op_take   (align_take)
    );

    // a stage stalls whenever the next one refuses its output
    fp_align_stage fp_align_stage_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (op_valid),
        .i_op      (op),
        .o_take    (align_take),
        .o_valid   (align_valid),
        .o_aligned (aligned),
        .i_stall   (!norm_take)
    );

    fp_addsub_normalize fp_addsub_normalize_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (align_valid),
        .i_aligned (aligned),
        .o_take    (norm_take),
        .o_valid   (norm_valid),
        .o_result  (norm_result),
        .i_stall   (!ret_take)
    );

    fpu_result_return fpu_result_return_inst (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_valid   (norm_valid),
        .i_result  (norm_result),
        .o_take    (ret_take),
        .o_res_req (o_res_req),
        .i_res_ack (i_res_ack),
        .o_result  (o_result)
    );

endmodule

/* logic/fpu_result_return.sv */
`timescale 1ns/1ps

module fpu_result_return
    import fpu_xfer_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_valid,
    input  fpu_result_t i_result,
    output logic        o_take,
    output logic        o_res_req,
    input  logic        i_res_ack,
    output fpu_result_t o_result
);

    localparam logic [1:0] R_EMPTY = 2'd0;
    localparam logic [1:0] R_REQ   = 2'd1;
    localparam logic [1:0] R_DROP  = 2'd2;

    logic [1:0]  state;
    fpu_result_t result_q;

    // only loads once the previous return has fully closed
    assign o_take = i_valid && (state == R_EMPTY);

    ////////////////////
    // return FSM
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= R_EMPTY;
        end else begin
            case (state)
                R_EMPTY: if (o_take) state <= R_REQ;
                R_REQ:   if (i_res_ack) state <= R_DROP;
                // wait for the consumer to release ack
                R_DROP:  if (!i_res_ack) state <= R_EMPTY;
                default: state <= R_EMPTY;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            result_q <= i_result;
        end
    end

    assign o_res_req = (state == R_REQ);
    assign o_result  = result_q;

    a_result_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        o_res_req |=> (!o_res_req || $stable(o_result)));

endmodule

/* logic/fp_addsub_normalize.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_addsub_normalize
    import fp_format_pkg::*, fpu_xfer_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_valid,
    input  fpu_aligned_t i_aligned,
    output logic         o_take,
    output logic         o_valid,
    output fpu_result_t  o_result,
    input  logic         i_stall
);

    localparam int SUM_W        = FP_MAN_W + 1;
    localparam int LZ_W         = $clog2(FP_MAN_W);
    localparam int EXPS_W       = `FP_EXP_W + 2;
    localparam int RND_W        = `FP_FRAC_W + 2;
    localparam int EXP_ALL_ONES = (1 << `FP_EXP_W) - 1;

    // result word selection
    localparam logic [1:0] SEL_NORMAL  = 2'd0;
    localparam logic [1:0] SEL_ZERO    = 2'd1;
    localparam logic [1:0] SEL_INF     = 2'd2;
    localparam logic [1:0] SEL_SPECIAL = 2'd3;

    logic                     eff_sub;
    logic [SUM_W-1:0]         sum;
    logic [FP_MAN_W-1:0]      man_sum;
    logic [FP_MAN_W-1:0]      man_norm;
    logic [LZ_W-1:0]          lz;
    logic                     sum_zero;
    logic signed [EXPS_W-1:0] exp_norm;
    logic signed [EXPS_W-1:0] exp_final;
    logic                     round_up;
    logic [RND_W-1:0]         man_rnd;
    logic [`FP_FRAC_W-1:0]    frac_final;
    logic [1:0]               sel;
    fpu_result_t              res;
    logic                     move;
    logic                     valid_q;

    ////////////////////
    // mantissa add
    ////////////////////
    always_comb begin
        eff_sub = i_aligned.sign_a ^ i_aligned.sign_b;
        // man_a is never smaller than man_b
        if (eff_sub) begin
            sum = {1'b0, i_aligned.man_a} - {1'b0, i_aligned.man_b};
        end else begin
            sum = {1'b0, i_aligned.man_a} + {1'b0, i_aligned.man_b};
        end

        // carry out shifts the sum right by one
        man_sum  = sum[SUM_W-1] ? sum[SUM_W-1:1] : sum[FP_MAN_W-1:0];
        sum_zero = (man_sum == '0);

        // leading one, highest set bit wins
        lz = '0;
        for (int i = 0; i < FP_MAN_W; i++) begin
            if (man_sum[i]) lz = LZ_W'(FP_MAN_W - 1 - i);
        end
        man_norm = man_sum << lz;
        exp_norm = EXPS_W'(i_aligned.exp) + EXPS_W'(sum[SUM_W-1]) - EXPS_W'(lz);
    end

    ////////////////////
    // round and pack
    ////////////////////
    always_comb begin
        // nearest even on the guard bits
        round_up = man_norm[`FP_XTRA_W-1]
                   && ((|man_norm[`FP_XTRA_W-2:0]) || man_norm[`FP_XTRA_W]);
        man_rnd  = {1'b0, man_norm[FP_MAN_W-1:`FP_XTRA_W]} + RND_W'(round_up);
        if (man_rnd[RND_W-1]) begin
            frac_final = man_rnd[`FP_FRAC_W:1];
            exp_final  = exp_norm + EXPS_W'(1);
        end else begin
            frac_final = man_rnd[`FP_FRAC_W-1:0];
            exp_final  = exp_norm;
        end

        res = '0;
        if (i_aligned.special) begin
            sel = SEL_SPECIAL;
        end else if (sum_zero) begin
            sel = SEL_ZERO;
        end else if (exp_final >= EXP_ALL_ONES) begin
            sel          = SEL_INF;
            res.overflow = 1'b1;
        end else if (exp_final <= 0) begin
            sel           = SEL_ZERO;
            res.underflow = 1'b1;
        end else begin
            sel = SEL_NORMAL;
        end

        case (sel)
            SEL_NORMAL: begin
                res.word.f.sign = i_aligned.sign_a;
                res.word.f.exp  = exp_final[`FP_EXP_W-1:0];
                res.word.f.frac = frac_final;
            end
            // exact cancellation is +0, a flush keeps the sign
            SEL_ZERO: res.word.f.sign = i_aligned.sign_a & !sum_zero;
            SEL_INF: begin
                res.word.f.sign = i_aligned.sign_a;
                res.word.f.exp  = FP_EXP_MAX;
            end
            default: res.word = i_aligned.special_word;
        endcase
    end

    assign move   = !valid_q || !i_stall;
    assign o_take = i_valid && move;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (move) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            o_result <= res;
        end
    end

    assign o_valid = valid_q;

    a_exp_max_is_inf_or_qnan: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_valid && o_result.word.f.exp == FP_EXP_MAX)
        |-> (o_result.word.f.frac == '0 || o_result.word.raw == FP_QNAN));

endmodule

/* logic/fp_align_stage.sv */
`timescale 1ns/1ps
`include "fpu_params.svh"

module fp_align_stage
    import fp_format_pkg::*, fpu_xfer_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_valid,
    input  fpu_operation_t i_op,
    output logic           o_take,
    output logic           o_valid,
    output fpu_aligned_t   o_aligned,
    input  logic           i_stall
);

    localparam int SHIFT_W = $clog2(`FP_SHIFT_MAX + 1);

    // subnormals fall into the zero class
    function automatic fp_class_e classify(input fp32_word_u w);
        if (w.f.exp == '0) begin
            return FP_ZERO;
        end else if (w.f.exp != FP_EXP_MAX) begin
            return FP_NORMAL;
        end else if (w.f.frac == '0) begin
            return FP_INF;
        end
        return FP_NAN;
    endfunction

    fp32_word_u           w_a;
    fp32_word_u           w_b_eff;
    fp32_word_u           w_big;
    fp32_word_u           w_small;
    fp_class_e            cls_a;
    fp_class_e            cls_b;
    logic                 a_lt_b;
    logic [`FP_EXP_W-1:0] exp_diff;
    logic [SHIFT_W-1:0]   shift_amt;
    logic [SHIFT_W-1:0]   shift_q;
    logic [FP_MAN_W-1:0]  man_big;
    logic [FP_MAN_W-1:0]  man_small;
    logic                 special;
    fp32_word_u           special_word;
    logic                 move;
    logic                 valid_q;

    ////////////////////
    // swap and align
    ////////////////////
    always_comb begin
        w_a     = i_op.a;
        w_b_eff = i_op.b;
        // subtract is an add with b negated
        w_b_eff.f.sign = i_op.b.f.sign ^ (i_op.op == FPU_SUB);

        a_lt_b  = {w_a.f.exp, w_a.f.frac} < {w_b_eff.f.exp, w_b_eff.f.frac};
        w_big   = a_lt_b ? w_b_eff : w_a;
        w_small = a_lt_b ? w_a : w_b_eff;

        exp_diff = w_big.f.exp - w_small.f.exp;
        if (exp_diff > `FP_SHIFT_MAX) begin
            shift_amt = SHIFT_W'(`FP_SHIFT_MAX);
        end else begin
            shift_amt = exp_diff[SHIFT_W-1:0];
        end

        man_big   = {1'b1, w_big.f.frac, {`FP_XTRA_W{1'b0}}};
        man_small = {1'b1, w_small.f.frac, {`FP_XTRA_W{1'b0}}} >> shift_amt;
    end

    ////////////////////
    // special results
    ////////////////////
    always_comb begin
        cls_a        = classify(w_a);
        cls_b        = classify(w_b_eff);
        special      = 1'b1;
        special_word = w_a;
        if (cls_a == FP_NAN || cls_b == FP_NAN) begin
            special_word.raw = FP_QNAN;
        end else if (cls_a == FP_INF && cls_b == FP_INF) begin
            // opposite infinities cancel into NaN
            if (w_a.f.sign != w_b_eff.f.sign) special_word.raw = FP_QNAN;
        end else if (cls_a == FP_INF) begin
            special_word = w_a;
        end else if (cls_b == FP_INF || (cls_a == FP_ZERO && cls_b == FP_NORMAL)) begin
            special_word = w_b_eff;
        end else if (cls_a == FP_ZERO && cls_b == FP_ZERO) begin
            special_word.raw    = '0;
            special_word.f.sign = w_a.f.sign & w_b_eff.f.sign;
        end else if (cls_b == FP_ZERO) begin
            special_word = w_a;
        end else begin
            special = 1'b0;
        end
    end

    assign move   = !valid_q || !i_stall;
    assign o_take = i_valid && move;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else if (move) begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            o_aligned.op           <= i_op.op;
            o_aligned.sign_a       <= w_big.f.sign;
            o_aligned.sign_b       <= w_small.f.sign;
            o_aligned.exp          <= w_big.f.exp;
            o_aligned.man_a        <= man_big;
            o_aligned.man_b        <= man_small;
            o_aligned.special      <= special;
            o_aligned.special_word <= special_word;
            shift_q                <= shift_amt;
        end
    end

    assign o_valid = valid_q;

    a_shift_saturated: assert property (@(posedge i_clk) disable iff (i_reset)
        o_valid |-> shift_q <= SHIFT_W'(`FP_SHIFT_MAX));

endmodule

/* logic/fpu_req_intake.sv */
`timescale 1ns/1ps

module fpu_req_intake
    import fpu_xfer_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset,
    input  logic           i_req,
    input  fpu_operation_t i_operation,
    output logic           o_ack,
    output logic           o_op_valid,
    output fpu_operation_t o_op,
    input  logic           i_op_take
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_ACK  = 2'd1;
    localparam logic [1:0] S_HOLD = 2'd2;

    logic [1:0]     state;
    logic           op_valid_q;
    fpu_operation_t op_q;
    logic           reg_free;
    logic           capture;

    // register frees up in the same cycle the align stage takes it
    assign reg_free = !op_valid_q || i_op_take;
    assign capture  = (state == S_IDLE) && i_req && reg_free;

    ////////////////////
    // handshake FSM
    ////////////////////
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (capture) state <= S_ACK;
                // producer holds req until it has seen ack
                S_ACK:  state <= S_HOLD;
                S_HOLD: if (!i_req) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            op_valid_q <= 1'b0;
        end else if (capture) begin
            op_valid_q <= 1'b1;
        end else if (i_op_take) begin
            op_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            op_q <= i_operation;
        end
    end

    assign o_ack      = (state != S_IDLE);
    assign o_op_valid = op_valid_q;
    assign o_op       = op_q;

    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(o_ack) |-> i_req);

endmodule

/* logic/fpu_xfer_pkg.sv */
`include "fpu_params.svh"

package fpu_xfer_pkg;

    import fp_format_pkg::*;

    // hidden one, stored fraction and guard bits
    localparam int FP_MAN_W = 1 + `FP_FRAC_W + `FP_XTRA_W;

    typedef enum logic {
        FPU_ADD,
        FPU_SUB
    } fpu_op_e;

    typedef struct packed {
        fpu_op_e    op;
        fp32_word_u a;
        fp32_word_u b;
    } fpu_operation_t;

    // sign_a belongs to the larger magnitude, sign_b is already effective
    typedef struct packed {
        fpu_op_e               op;
        logic                  sign_a;
        logic                  sign_b;
        logic [`FP_EXP_W-1:0]  exp;
        logic [FP_MAN_W-1:0]   man_a;
        logic [FP_MAN_W-1:0]   man_b;
        logic                  special;
        fp32_word_u            special_word;
    } fpu_aligned_t;

    typedef struct packed {
        fp32_word_u word;
        logic       overflow;
        logic       underflow;
    } fpu_result_t;

endpackage

/* logic/fp_format_pkg.sv */
`include "fpu_params.svh"

package fp_format_pkg;

    localparam int FP_WORD_W = 1 + `FP_EXP_W + `FP_FRAC_W;

    // all-ones exponent marks infinity and NaN
    localparam logic [`FP_EXP_W-1:0] FP_EXP_MAX = '1;
    localparam logic [FP_WORD_W-1:0] FP_QNAN    = 32'h7fc0_0000;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp32_fields_t;

    // raw bits for transport, fields for arithmetic
    typedef union packed {
        logic [FP_WORD_W-1:0] raw;
        fp32_fields_t         f;
    } fp32_word_u;

    typedef enum logic [1:0] {
        FP_ZERO,
        FP_NORMAL,
        FP_INF,
        FP_NAN
    } fp_class_e;

endpackage

/* logic/fpu_params.svh */
`ifndef FPU_PARAMS_SVH
`define FPU_PARAMS_SVH

// single-precision field widths
`define FP_EXP_W      8
`define FP_FRAC_W     23

// guard bits kept below the mantissa during alignment
`define FP_XTRA_W     4

// exponent bias of the binary32 format
`define FP_BIAS       127

// largest useful alignment shift, a 28-bit field is empty beyond it
`define FP_SHIFT_MAX  27

`endif
